//--- Makefile
# Verilator build and run of the M-extension testbench

VERILATOR ?= verilator
TOP       ?= tb_m_ext
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/divu_int.sv
// divu_int: iterative unsigned restoring divider, one quotient bit per cycle
`timescale 1ns/1ps
`default_nettype none

module divu_int #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  logic            flush_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] quotient_o,
    output logic [XLEN-1:0] remainder_o,
    output logic            done_o
);

    localparam int CW = $clog2(XLEN);

    muldiv_pkg::div_state_e state_q;
    muldiv_pkg::div_state_e state_d;

    logic [CW-1:0]   cnt_q;
    logic [XLEN-1:0] quo_q;       // dividend shifts out, quotient shifts in
    logic [XLEN-1:0] rem_q;       // partial remainder
    logic [XLEN-1:0] dvs_q;

    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   trial;
    logic            last_bit;

    // shift next dividend bit into the partial remainder and try the subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};
    assign last_bit  = (cnt_q == CW'(XLEN - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::DIV_IDLE: begin
                if (start_i) state_d = muldiv_pkg::DIV_CALC;
            end
            muldiv_pkg::DIV_CALC: begin
                if (last_bit) state_d = muldiv_pkg::DIV_DONE;
            end
            muldiv_pkg::DIV_DONE: begin
                state_d = start_i ? muldiv_pkg::DIV_CALC : muldiv_pkg::DIV_IDLE;
            end
            default: begin
                state_d = muldiv_pkg::DIV_IDLE;
            end
        endcase
        if (flush_i) state_d = muldiv_pkg::DIV_IDLE;  // abandon the division
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= muldiv_pkg::DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == muldiv_pkg::DIV_CALC) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    // datapath, loaded on start and stepped while calculating
    always_ff @(posedge clk) begin
        if (start_i && state_q != muldiv_pkg::DIV_CALC) begin
            quo_q <= dividend_i;
            rem_q <= '0;
            dvs_q <= divisor_i;
        end else if (state_q == muldiv_pkg::DIV_CALC) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];               // subtract fits
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];           // restore
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // zero divisor always subtracts, giving all ones and the dividend back
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;
    assign done_o      = (state_q == muldiv_pkg::DIV_DONE);

endmodule

`default_nettype wire

//--- hdl/m_ext_top.sv
// m_ext_top: M-extension subsystem top level holding the muldiv unit
`timescale 1ns/1ps
`default_nettype none

module m_ext_top #(
    parameter int XLEN = 32                 // any even width
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // execute stage command
    input  muldiv_pkg::muldiv_op_e op_i,
    input  logic [XLEN-1:0]        operand_a_i,
    input  logic [XLEN-1:0]        operand_b_i,

    // pipeline controls from forwarding logic
    input  logic                   stall_i,
    input  logic                   flush_i,

    // status and result toward forwarding and writeback
    output logic                   busy_o,
    output logic                   ack_o,
    output logic [XLEN-1:0]        result_o
);

    logic            busy;
    logic            ack;
    logic [XLEN-1:0] result;

    muldiv #(
        .XLEN(XLEN)
    ) i_muldiv (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .busy_o      (busy),
        .ack_o       (ack),
        .result_o    (result)
    );

    assign busy_o   = busy;
    assign ack_o    = ack;
    assign result_o = result;

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
// mul_unit: single cycle multiplier with signed, mixed and unsigned products
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int XLEN = 32
) (
    input  muldiv_pkg::muldiv_op_e op_i,
    input  logic [XLEN-1:0]        a_i,
    input  logic [XLEN-1:0]        b_i,
    output logic [XLEN-1:0]        product_o
);

    logic signed [2*XLEN-1:0] prod_ss;
    logic signed [2*XLEN-1:0] prod_su;
    logic        [2*XLEN-1:0] prod_uu;

    // both operands signed
    assign prod_ss = $signed(a_i) * $signed(b_i);

    // rs1 signed, rs2 zero extended by one bit so it stays positive
    assign prod_su = $signed(a_i) * $signed({1'b0, b_i});

    // plain unsigned product, also gives the low half for MUL
    assign prod_uu = a_i * b_i;

    always_comb begin
        case (op_i)
            muldiv_pkg::MUL: begin
                product_o = prod_uu[XLEN-1:0];        // low half is sign agnostic
            end
            muldiv_pkg::MULH: begin
                product_o = prod_ss[2*XLEN-1:XLEN];
            end
            muldiv_pkg::MULHSU: begin
                product_o = prod_su[2*XLEN-1:XLEN];
            end
            muldiv_pkg::MULHU: begin
                product_o = prod_uu[2*XLEN-1:XLEN];
            end
            default: begin
                product_o = '0;                       // divide ops and NONE
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/muldiv.sv
// control FSM, operand capture, sign fix-up and output register of the multiply/divide unit
`timescale 1ns/1ps
`default_nettype none

module muldiv #(
    parameter int XLEN = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  logic [XLEN-1:0]        operand_a_i,
    input  logic [XLEN-1:0]        operand_b_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output logic                   busy_o,
    output logic                   ack_o,
    output logic [XLEN-1:0]        result_o
);

    muldiv_pkg::muldiv_state_e state_q;
    muldiv_pkg::muldiv_state_e state_d;
    muldiv_pkg::muldiv_op_e    op_q;

    logic [XLEN-1:0] a_q;           // raw operands as issued
    logic [XLEN-1:0] b_q;
    logic            fresh_q;       // first cycle after acceptance
    logic            div_start_q;
    logic [XLEN-1:0] dvd_mag_q;
    logic [XLEN-1:0] dvs_mag_q;
    logic            a_neg_q;
    logic            b_neg_q;
    logic            div_fin_q;     // divider finished and result not yet taken
    logic            ack_q;
    logic [XLEN-1:0] result_q;

    logic            accept;
    logic            deliver;
    logic            is_div;
    logic            is_signed_div;
    logic            a_neg;
    logic            b_neg;
    logic            b_zero;
    logic            res_ready;
    logic [XLEN-1:0] res_next;
    logic [XLEN-1:0] mul_res;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic            div_done;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] div_res;

    // ack goes out this cycle unless held by stall
    assign deliver = ack_q && !stall_i;
    assign accept  = (op_i != muldiv_pkg::NONE) && !stall_i && !flush_i &&
                     (state_q == muldiv_pkg::MD_IDLE || deliver);

    assign is_div        = op_q[3];
    assign is_signed_div = (op_q == muldiv_pkg::DIV) || (op_q == muldiv_pkg::REM);
    assign a_neg         = is_signed_div && a_q[XLEN-1];
    assign b_neg         = is_signed_div && b_q[XLEN-1];
    assign b_zero        = (b_q == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::MD_IDLE: begin
                if (accept) state_d = muldiv_pkg::MD_BUSY;
            end
            muldiv_pkg::MD_BUSY: begin
                if (deliver && !accept) state_d = muldiv_pkg::MD_IDLE;
            end
            default: begin
                state_d = muldiv_pkg::MD_IDLE;
            end
        endcase
        if (flush_i) state_d = muldiv_pkg::MD_IDLE;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= muldiv_pkg::MD_IDLE;
            op_q        <= muldiv_pkg::NONE;
            fresh_q     <= 1'b0;
            div_start_q <= 1'b0;
            div_fin_q   <= 1'b0;
        end else begin
            state_q     <= state_d;
            fresh_q     <= accept;
            div_start_q <= fresh_q && is_div && !flush_i;   // one cycle after accept
            if (accept) op_q <= op_i;
            if (flush_i || accept) begin
                div_fin_q <= 1'b0;
            end else if (div_done) begin
                div_fin_q <= 1'b1;              // keep it while stalled
            end
        end
    end

    // raw operands on accept, magnitudes one cycle later with the start pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= operand_a_i;
            b_q <= operand_b_i;
        end
        if (fresh_q) begin
            a_neg_q   <= a_neg;
            b_neg_q   <= b_neg;
            dvd_mag_q <= a_neg ? (~a_q + 1'b1) : a_q;
            dvs_mag_q <= b_neg ? (~b_q + 1'b1) : b_q;
        end
    end

    mul_unit #(
        .XLEN(XLEN)
    ) i_mul_unit (
        .op_i      (op_q),
        .a_i       (a_q),
        .b_i       (b_q),
        .product_o (mul_res)
    );

    divu_int #(
        .XLEN(XLEN)
    ) i_divu_int (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (div_start_q),
        .flush_i     (flush_i),
        .dividend_i  (dvd_mag_q),
        .divisor_i   (dvs_mag_q),
        .quotient_o  (quo),
        .remainder_o (rem),
        .done_o      (div_done)
    );

    // sign fix-up where a zero divisor keeps the all ones quotient
    assign quo_fix = ((a_neg_q ^ b_neg_q) && !b_zero) ? (~quo + 1'b1) : quo;
    assign rem_fix = a_neg_q ? (~rem + 1'b1) : rem;        // remainder takes dividend sign
    assign div_res = op_q[1] ? rem_fix : quo_fix;          // REM/REMU have bit 1 set

    // multiplies are ready the cycle after acceptance and divides once the divider is done
    assign res_ready = (state_q == muldiv_pkg::MD_BUSY) && !ack_q &&
                       (!is_div || div_done || div_fin_q);
    assign res_next  = is_div ? div_res : mul_res;

    // output register that holds on stall and clears on flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            ack_q    <= 1'b0;
            result_q <= '0;
        end else if (!stall_i) begin
            ack_q <= res_ready;
            if (res_ready) result_q <= res_next;
        end
    end

    assign busy_o   = (state_q == muldiv_pkg::MD_BUSY);
    assign ack_o    = ack_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

//--- hdl/muldiv_pkg.sv
// op code encoding and FSM state enums for the multiply/divide unit
`default_nettype none

package muldiv_pkg;

    // bit 3 set marks a divide class op
    typedef enum logic [3:0] {
        NONE   = 4'd0,
        MUL    = 4'd1,
        MULH   = 4'd2,
        MULHSU = 4'd3,
        MULHU  = 4'd4,
        DIV    = 4'd8,
        DIVU   = 4'd9,
        REM    = 4'd10,
        REMU   = 4'd11
    } muldiv_op_e;

    // control FSM in muldiv
    typedef enum logic {
        MD_IDLE = 1'b0,
        MD_BUSY = 1'b1
    } muldiv_state_e;

    // iterative divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_CALC = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

//--- list.f
hdl/muldiv_pkg.sv
hdl/mul_unit.sv
hdl/divu_int.sv
hdl/muldiv.sv
hdl/m_ext_top.sv
tests/tb_clk_gen.sv
tests/tb_m_ext.sv

//--- tests/tb_clk_gen.sv
// tb_clk_gen: 10 ns clock and active low reset held for five cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                  // released away from the active edge
    end

endmodule

`default_nettype wire

//--- tests/tb_m_ext.sv
// testbench for the M-extension unit with LFSR stimulus, reference model, ack checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_m_ext;

    localparam int XLEN       = 32;
    localparam int N_MUL      = 200;
    localparam int N_DIV      = 200;
    localparam int N_CORNER   = 200;                 // 8 ops over 5 x 5 operand values
    localparam int N_EXTRA    = 11;                  // stall and flush phases
    localparam int MAX_CYCLES = 200 * (N_MUL + N_DIV + N_CORNER + N_EXTRA) + 500;

    logic                   clk;
    logic                   rst_n;
    muldiv_pkg::muldiv_op_e op;
    logic [31:0]            opa;
    logic [31:0]            opb;
    logic                   stall;
    logic                   flush;
    logic                   busy;
    logic                   ack;
    logic [31:0]            result;

    logic [15:0] lfsr_q    = 16'd12;
    int          cycle_cnt = 0;
    int          err_value = 0;
    int          err_proto = 0;
    logic [31:0] exp_q[$];                           // expected results in issue order
    int          due_q[$];                           // ack cycle of timed ops or -1
    string       tag_q[$];

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    m_ext_top #(
        .XLEN(XLEN)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_i        (op),
        .operand_a_i (opa),
        .operand_b_i (opb),
        .stall_i     (stall),
        .flush_i     (flush),
        .busy_o      (busy),
        .ack_o       (ack),
        .result_o    (result)
    );

    // fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // mix of wide, narrow and small negative values
    function automatic logic [31:0] mixed_operand();
        logic [1:0] mode;
        mode = 2'(rand_bits(2));
        case (mode)
            2'd0:    return rand_bits(32);
            2'd1:    return rand_bits(16);
            2'd2:    return rand_bits(4);            // zero now and then
            default: return ~rand_bits(8);
        endcase
    endfunction

    // RISC-V M rules on 64 bit arithmetic
    function automatic logic [31:0] ref_muldiv(input muldiv_pkg::muldiv_op_e f,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic signed [63:0] p_ss;
        logic signed [63:0] p_su;
        logic signed [63:0] q_s;
        logic signed [63:0] r_s;
        logic [63:0]        pu;
        logic               zero;
        logic               ovf;
        logic [31:0]        r;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ub   = {32'd0, b};
        p_ss = sa * sb;
        p_su = sa * ub;
        pu   = {32'd0, a} * {32'd0, b};
        zero = (b == 32'd0);
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        q_s  = zero ? 64'sd0 : sa / sb;             // truncates toward zero
        r_s  = zero ? 64'sd0 : sa % sb;             // sign of the dividend
        case (f)
            muldiv_pkg::MUL:    r = pu[31:0];
            muldiv_pkg::MULH:   r = p_ss[63:32];
            muldiv_pkg::MULHSU: r = p_su[63:32];
            muldiv_pkg::MULHU:  r = pu[63:32];
            muldiv_pkg::DIV:    r = zero ? 32'hffff_ffff : (ovf ? a : q_s[31:0]);
            muldiv_pkg::DIVU:   r = zero ? 32'hffff_ffff : a / b;
            muldiv_pkg::REM:    r = zero ? a : (ovf ? 32'd0 : r_s[31:0]);
            muldiv_pkg::REMU:   r = zero ? a : a % b;
            default:            r = 32'd0;
        endcase
        return r;
    endfunction

    // waits until the DUT can accept and presents the op for one cycle
    task automatic issue(input muldiv_pkg::muldiv_op_e f, input logic [31:0] a,
                         input logic [31:0] b, input int lat, input bit tracked);
        while (busy && !ack) @(negedge clk);        // idle or delivering an ack
        if (tracked) begin
            exp_q.push_back(ref_muldiv(f, a, b));
            due_q.push_back(lat > 0 ? cycle_cnt + lat : -1);
            tag_q.push_back($sformatf("%s a=%h b=%h", f.name(), a, b));
        end
        op  = f;
        opa = a;
        opb = b;
        @(negedge clk);
        op  = muldiv_pkg::NONE;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || busy) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    // an ack counts once it is delivered with stall low
    always @(posedge clk) begin
        if (rst_n && ack && !stall) begin
            if (exp_q.size() == 0) begin
                $display("unexpected ack at %0t ns with no operation outstanding", $time);
                err_proto++;
            end else begin
                if (result !== exp_q[0]) begin
                    $display("[ERROR] %0t ns: %s gave %h, expected %h",
                             $time, tag_q[0], result, exp_q[0]);
                    err_value++;
                end
                if (due_q[0] >= 0 && cycle_cnt != due_q[0]) begin
                    $display("[ERROR] %0t ns: %s acked %0d cycles off its latency",
                             $time, tag_q[0], cycle_cnt - due_q[0]);
                    err_value++;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(tag_q.pop_front());
            end
        end
        cycle_cnt++;
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) @(negedge clk);
        $display("timeout after %0d cycles, %0d acks missing, %0d value and %0d protocol errors",
                 cycle_cnt, exp_q.size(), err_value, err_proto);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0]            vals [5];
        muldiv_pkg::muldiv_op_e ops [8];
        muldiv_pkg::muldiv_op_e f;
        logic [31:0]            held;
        op    = muldiv_pkg::NONE;
        opa   = '0;
        opb   = '0;
        stall = 1'b0;
        flush = 1'b0;
        vals  = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        ops   = '{muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU,
                  muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::REM, muldiv_pkg::REMU};
        wait (rst_n === 1'b1);
        @(negedge clk);
        if (busy !== 1'b0 || ack !== 1'b0 || result !== 32'd0) begin
            $display("[ERROR] %0t ns: after reset busy %b ack %b result %h", $time, busy, ack,
                     result);
            err_value++;
        end
        for (int i = 0; i < N_MUL; i++) begin
            f = muldiv_pkg::muldiv_op_e'(4'd1 + 4'(rand_bits(2)));
            issue(f, mixed_operand(), mixed_operand(), 2, 1'b1);
        end
        drain();
        for (int i = 0; i < N_DIV; i++) begin
            f = muldiv_pkg::muldiv_op_e'(4'd8 + 4'(rand_bits(2)));
            issue(f, mixed_operand(), mixed_operand(), 0, 1'b1);   // next one goes in the ack cycle
        end
        drain();
        foreach (ops[k]) begin
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    issue(ops[k], vals[i], vals[j], (ops[k] < muldiv_pkg::DIV) ? 2 : 0, 1'b1);
                end
            end
        end
        drain();
        // stall over an ack already on the outputs while a new op is offered
        issue(muldiv_pkg::MULHU, 32'hdead_beef, 32'h1234_5678, 0, 1'b1);
        while (!ack) @(negedge clk);
        stall = 1'b1;
        held  = result;
        op    = muldiv_pkg::MUL;
        repeat (6) begin
            @(negedge clk);
            if (ack !== 1'b1 || result !== held) begin
                $display("[ERROR] %0t ns: ack %b result %h moved during stall", $time, ack, result);
                err_value++;
            end
        end
        stall = 1'b0;
        op    = muldiv_pkg::NONE;
        drain();
        // divide that finishes while stalled
        issue(muldiv_pkg::REM, 32'h8000_0007, 32'h0000_0003, 0, 1'b1);
        stall = 1'b1;
        held  = result;
        op    = muldiv_pkg::DIVU;
        repeat (XLEN + 10) begin
            @(negedge clk);
            if (ack !== 1'b0 || result !== held) begin
                $display("[ERROR] %0t ns: ack %b result %h moved during stall", $time, ack, result);
                err_value++;
            end
        end
        stall = 1'b0;
        op    = muldiv_pkg::NONE;
        drain();
        // flush at start, on the start pulse and mid calculation
        for (int d = 0; d < 3; d++) begin
            issue(muldiv_pkg::DIV, rand_bits(32), rand_bits(8), 0, 1'b0);
            repeat ((d == 2) ? XLEN / 2 : d) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            if (busy !== 1'b0 || ack !== 1'b0 || result !== 32'd0) begin
                $display("[ERROR] %0t ns: after flush busy %b ack %b result %h", $time, busy,
                         ack, result);
                err_value++;
            end
            repeat (XLEN + 8) @(negedge clk);       // room for a stale divide to finish
            issue(muldiv_pkg::DIVU, rand_bits(32), rand_bits(16), 0, 1'b1);
            issue(muldiv_pkg::MULH, rand_bits(32), rand_bits(32), 2, 1'b1);
            drain();
        end
        $display("run complete: %0d value errors, %0d protocol errors", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
